// ==== rtl/lvds_rx_cfg_pkg.sv ====
`default_nettype none

// structural constants shared by every block of the receiver
package lvds_rx_cfg_pkg;

	// number of serial lanes
	localparam int NUM_CHANNELS = 4;

	// bits per deserialized word, one bit arrives per fast_clock cycle
	localparam int DESER_FACTOR = 8;

	// slip offsets run from 0 up to DESER_FACTOR-1
	localparam int SLIP_CNT_W = 3;

	// width of the pll lock qualifier counter
	localparam int LOCK_CNT_W = 8;

endpackage : lvds_rx_cfg_pkg

`default_nettype wire

// ==== rtl/lvds_rx_types_pkg.sv ====
`default_nettype none

package lvds_rx_types_pkg;
	import lvds_rx_cfg_pkg::*;

	// one received word, the first bit on the wire lands in the MSB
	typedef logic [DESER_FACTOR-1:0] channel_word_t;

	// current bit-slip offset of one channel
	typedef logic [SLIP_CNT_W-1:0] slip_cnt_t;

	// the receive bus is a flat vector to the outside world and a set of
	// per-channel words inside, with channel 0 in the lowest slice
	typedef union packed {
		logic [NUM_CHANNELS*DESER_FACTOR-1:0] flat;
		channel_word_t [NUM_CHANNELS-1:0] lane;
	} rx_bus_u;

endpackage : lvds_rx_types_pkg

`default_nettype wire

// ==== rtl/lock_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lock_timing_gen
	import lvds_rx_cfg_pkg::*;
#(
	parameter int LOCK_COUNT = 16,
	parameter int REGISTERED_OUTPUT = 1
) (
	input  logic fast_clock,
	input  logic rst_n,
	input  logic pll_enable,
	output logic rx_locked,
	output logic load_en,
	output logic rx_out_valid
);

	localparam int WORD_CNT_W = $clog2(DESER_FACTOR);
	localparam logic [LOCK_CNT_W-1:0] LOCK_TARGET = LOCK_CNT_W'(LOCK_COUNT);
	localparam logic [WORD_CNT_W-1:0] WORD_LAST = WORD_CNT_W'(DESER_FACTOR - 1);

	logic [LOCK_CNT_W-1:0] lock_cnt;
	logic raw_lock;
	logic [WORD_CNT_W-1:0] word_cnt;

	if (LOCK_COUNT < 1 || LOCK_COUNT >= 2 ** LOCK_CNT_W) begin : g_bad_lock_count
		$error("LOCK_COUNT %0d does not fit the lock counter", LOCK_COUNT);
	end

	// the pll is treated as locked once enable has been held long enough
	always_ff @(posedge fast_clock) begin
		if (!rst_n) begin
			lock_cnt <= '0;
		end else if (!pll_enable) begin
			lock_cnt <= '0;
		end else if (lock_cnt != LOCK_TARGET) begin
			lock_cnt <= lock_cnt + 1'b1;
		end
	end

	// a low enable kills the raw lock at once, so rx_locked drops on the next edge
	assign raw_lock = pll_enable && (lock_cnt == LOCK_TARGET);

	// second stage of the lock synchronizer
	always_ff @(posedge fast_clock) begin
		if (!rst_n) begin
			rx_locked <= 1'b0;
		end else begin
			rx_locked <= raw_lock;
		end
	end

	// word boundary counter, held at zero until lock so that the first word
	// starts with the first bit after rx_locked rises
	always_ff @(posedge fast_clock) begin
		if (!rst_n || !rx_locked) begin
			word_cnt <= '0;
		end else if (word_cnt == WORD_LAST) begin
			word_cnt <= '0;
		end else begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	assign load_en = rx_locked && (word_cnt == WORD_LAST);

	if (REGISTERED_OUTPUT != 0) begin : g_valid_reg
		logic valid_q;

		// raw_lock here matches rx_locked in the cycle the strobe appears
		always_ff @(posedge fast_clock) begin
			if (!rst_n) begin
				valid_q <= 1'b0;
			end else begin
				valid_q <= load_en && raw_lock;
			end
		end

		assign rx_out_valid = valid_q;
	end else begin : g_valid_comb
		assign rx_out_valid = load_en;
	end

endmodule : lock_timing_gen

`default_nettype wire

// ==== rtl/bitslip_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitslip_ctrl
	import lvds_rx_cfg_pkg::*;
	import lvds_rx_types_pkg::*;
#(
	parameter int DATA_ALIGN_ROLLOVER = 4
) (
	input  logic      fast_clock,
	input  logic      rst_n,
	input  logic      align_req,
	input  logic      cda_reset,
	output slip_cnt_t slip_cnt,
	output logic      cda_max
);

	localparam slip_cnt_t SLIP_LAST = slip_cnt_t'(DATA_ALIGN_ROLLOVER - 1);

	logic align_q;
	logic slip_pulse;

	if (DATA_ALIGN_ROLLOVER < 1 || DATA_ALIGN_ROLLOVER > DESER_FACTOR) begin : g_bad_rollover
		$error("DATA_ALIGN_ROLLOVER %0d is outside 1 to %0d",
			DATA_ALIGN_ROLLOVER, DESER_FACTOR);
	end

	// registered copy of the align request for edge detection
	always_ff @(posedge fast_clock) begin
		if (!rst_n) begin
			align_q <= 1'b0;
		end else begin
			align_q <= align_req;
		end
	end

	// a request held high for several cycles slips only once
	assign slip_pulse = align_req && !align_q;

	// cda_reset wins over a slip arriving in the same cycle
	always_ff @(posedge fast_clock) begin
		if (!rst_n || cda_reset) begin
			slip_cnt <= '0;
		end else if (slip_pulse) begin
			if (slip_cnt == SLIP_LAST) begin
				slip_cnt <= '0;
			end else begin
				slip_cnt <= slip_cnt + 1'b1;
			end
		end
	end

	// high while the next slip would roll the channel back to offset 0
	assign cda_max = (slip_cnt == SLIP_LAST);

endmodule : bitslip_ctrl

`default_nettype wire

// ==== rtl/rx_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_channel
	import lvds_rx_cfg_pkg::*;
	import lvds_rx_types_pkg::*;
#(
	parameter int DATA_ALIGN_ROLLOVER = 4,
	parameter int REGISTERED_OUTPUT = 1
) (
	input  logic          fast_clock,
	input  logic          rst_n,
	input  logic          serial_in,
	input  logic          load_en,
	input  logic          align_req,
	input  logic          cda_reset,
	output channel_word_t word,
	output logic          cda_max
);

	// past bits kept in the shift register, the live input makes up the rest
	localparam int HIST_W = 2 * DESER_FACTOR - 1;

	logic [HIST_W-1:0] bit_hist;
	logic [HIST_W:0] window;
	slip_cnt_t slip_cnt;
	channel_word_t cap_word;

	bitslip_ctrl #(
		.DATA_ALIGN_ROLLOVER(DATA_ALIGN_ROLLOVER)
	) u_bitslip (
		.fast_clock(fast_clock),
		.rst_n     (rst_n),
		.align_req (align_req),
		.cda_reset (cda_reset),
		.slip_cnt  (slip_cnt),
		.cda_max   (cda_max)
	);

	// newest bit enters at the bottom, the oldest falls off the top
	always_ff @(posedge fast_clock) begin
		bit_hist <= {bit_hist[HIST_W-2:0], serial_in};
	end

	// the bit on the wire during load_en is the last bit of the word at offset 0
	assign window = {bit_hist, serial_in};

	// each slip moves the word boundary one bit further into the past,
	// and the older bits end up in the MSB positions of the word
	assign cap_word = window[slip_cnt +: DESER_FACTOR];

	if (REGISTERED_OUTPUT != 0) begin : g_out_reg
		channel_word_t word_q;

		// the word is held for a whole word period after its load cycle
		always_ff @(posedge fast_clock) begin
			if (load_en) begin
				word_q <= cap_word;
			end
		end

		assign word = word_q;
	end else begin : g_out_comb
		// only meaningful in the load_en cycle itself
		assign word = cap_word;
	end

endmodule : rx_channel

`default_nettype wire

// ==== rtl/lvds_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvds_rx_top
	import lvds_rx_cfg_pkg::*;
	import lvds_rx_types_pkg::*;
#(
	parameter int DATA_ALIGN_ROLLOVER = 4,
	parameter int LOCK_COUNT = 16,
	parameter int REGISTERED_OUTPUT = 1
) (
	input  logic                                 fast_clock,
	input  logic                                 rst_n,
	input  logic [NUM_CHANNELS-1:0]              rx_in,
	input  logic                                 pll_enable,
	input  logic [NUM_CHANNELS-1:0]              rx_channel_data_align,
	input  logic [NUM_CHANNELS-1:0]              rx_cda_reset,
	output logic [NUM_CHANNELS*DESER_FACTOR-1:0] rx_out,
	output logic                                 rx_out_valid,
	output logic                                 rx_locked,
	output logic [NUM_CHANNELS-1:0]              rx_cda_max
);

	logic load_en;
	channel_word_t lane_word [NUM_CHANNELS];
	rx_bus_u rx_bus;

	if (REGISTERED_OUTPUT != 0 && REGISTERED_OUTPUT != 1) begin : g_bad_reg_out
		$error("REGISTERED_OUTPUT must be 0 or 1, got %0d", REGISTERED_OUTPUT);
	end

	// one lock and word timing source serves all lanes
	lock_timing_gen #(
		.LOCK_COUNT       (LOCK_COUNT),
		.REGISTERED_OUTPUT(REGISTERED_OUTPUT)
	) u_lock_timing (
		.fast_clock  (fast_clock),
		.rst_n       (rst_n),
		.pll_enable  (pll_enable),
		.rx_locked   (rx_locked),
		.load_en     (load_en),
		.rx_out_valid(rx_out_valid)
	);

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
		rx_channel #(
			.DATA_ALIGN_ROLLOVER(DATA_ALIGN_ROLLOVER),
			.REGISTERED_OUTPUT  (REGISTERED_OUTPUT)
		) u_rx_channel (
			.fast_clock(fast_clock),
			.rst_n     (rst_n),
			.serial_in (rx_in[i]),
			.load_en   (load_en),
			.align_req (rx_channel_data_align[i]),
			.cda_reset (rx_cda_reset[i]),
			.word      (lane_word[i]),
			.cda_max   (rx_cda_max[i])
		);
	end

	// channel words go in by lane, the port sees the flat view
	always_comb begin
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			rx_bus.lane[i] = lane_word[i];
		end
	end

	assign rx_out = rx_bus.flat;

endmodule : lvds_rx_top

`default_nettype wire

// ==== sim/lvds_rx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvds_rx_checker
	import lvds_rx_cfg_pkg::*;
#(
	parameter int DATA_ALIGN_ROLLOVER = 4
) (
	input  logic                    fast_clock,
	input  logic                    rst_n,
	input  logic                    pll_enable,
	input  logic                    rx_locked,
	input  logic                    rx_out_valid,
	input  logic [NUM_CHANNELS-1:0] rx_cda_reset,
	input  logic [NUM_CHANNELS-1:0] rx_cda_max
);

	int fail_count = 0;

	// a word strobe only ever appears while the receiver is locked
	assert property (@(posedge fast_clock) disable iff (!rst_n)
		rx_out_valid |-> rx_locked)
		else begin
			$error("rx_out_valid high while rx_locked is low");
			fail_count++;
		end

	// losing the pll enable drops the lock on the next edge
	assert property (@(posedge fast_clock) disable iff (!rst_n)
		!pll_enable |=> !rx_locked)
		else begin
			$error("rx_locked stayed high after pll_enable went low");
			fail_count++;
		end

	// one strobe per word, never two within a word period
	assert property (@(posedge fast_clock) disable iff (!rst_n)
		rx_out_valid |=> !rx_out_valid [*DESER_FACTOR-1])
		else begin
			$error("rx_out_valid repeated within one word period");
			fail_count++;
		end

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_slip_reset
		if (DATA_ALIGN_ROLLOVER > 1) begin : g_max_clear
			assert property (@(posedge fast_clock) disable iff (!rst_n)
				rx_cda_reset[i] |=> !rx_cda_max[i])
				else begin
					$error("rx_cda_max still high after rx_cda_reset");
					fail_count++;
				end
		end
	end

endmodule : lvds_rx_checker

`default_nettype wire

// ==== sim/lvds_rx_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvds_rx_monitor
	import lvds_rx_cfg_pkg::*;
#(
	parameter int LOCK_COUNT = 16,
	parameter int DATA_ALIGN_ROLLOVER = 4
) (
	input  logic                                 fast_clock,
	input  logic                                 rst_n,
	input  logic                                 pll_enable,
	input  logic [NUM_CHANNELS-1:0]              rx_in,
	input  logic [NUM_CHANNELS-1:0]              rx_channel_data_align,
	input  logic [NUM_CHANNELS-1:0]              rx_cda_reset,
	input  logic [NUM_CHANNELS*DESER_FACTOR-1:0] rx_out,
	input  logic                                 rx_out_valid,
	input  logic                                 rx_locked,
	input  logic [NUM_CHANNELS-1:0]              rx_cda_max
);

	localparam int BUS_W = NUM_CHANNELS * DESER_FACTOR;
	localparam int MAX_BITS = 4096;

	int mismatch_count = 0;
	int other_count = 0;
	int valid_count = 0;

	// every bit seen on the wire since lock, used to rebuild the words
	logic [NUM_CHANNELS-1:0] tx_bits [MAX_BITS];
	int bit_count;
	logic [BUS_W-1:0] model_q [$];
	logic [BUS_W-1:0] file_word_q [$];
	logic [NUM_CHANNELS-1:0] file_care_q [$];
	int slip [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] align_prev;
	int en_cycles;
	logic en_at_edge;
	logic locked_prev;
	int cycle = 0;
	int last_valid_cycle = -1;

	// word n ends s bits before the boundary, bits before the stream are 0
	function automatic logic [DESER_FACTOR-1:0] word_at(input int ch, input int n, input int s);
		logic [DESER_FACTOR-1:0] w;
		int idx;
		for (int k = 0; k < DESER_FACTOR; k++) begin
			idx = n * DESER_FACTOR - s + k;
			w[DESER_FACTOR-1-k] = (idx < 0) ? 1'b0 : tx_bits[idx][ch];
		end
		return w;
	endfunction

	task automatic add_expect(input logic [BUS_W-1:0] words, input logic [NUM_CHANNELS-1:0] care);
		file_word_q.push_back(words);
		file_care_q.push_back(care);
	endtask

	task automatic finish_checks(input int min_words);
		if (file_word_q.size() != 0) begin
			$display("ERROR at %0t: %0d file frames never got a word strobe",
				$time, file_word_q.size());
			other_count++;
		end
		if (valid_count < min_words) begin
			$display("ERROR at %0t: only %0d words received, at least %0d were due",
				$time, valid_count, min_words);
			other_count++;
		end
	endtask

	always @(posedge fast_clock) begin
		logic [BUS_W-1:0] exp_word;
		if (!rst_n) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				slip[ch] = 0;
			end
			align_prev = '0;
			en_cycles = 0;
			en_at_edge = 1'b0;
			bit_count = 0;
			model_q.delete();
		end else begin
			en_at_edge = pll_enable;
			en_cycles = pll_enable ? en_cycles + 1 : 0;
			if (rx_locked) begin
				tx_bits[bit_count] = rx_in;
				bit_count++;
				if (bit_count % DESER_FACTOR == 0) begin
					for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
						exp_word[ch*DESER_FACTOR +: DESER_FACTOR] =
							word_at(ch, bit_count / DESER_FACTOR - 1, slip[ch]);
					end
					model_q.push_back(exp_word);
				end
			end else begin
				bit_count = 0;
				model_q.delete();
			end
			// slip offsets move after the word of this edge was taken
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				if (rx_cda_reset[ch]) begin
					slip[ch] = 0;
				end else if (rx_channel_data_align[ch] && !align_prev[ch]) begin
					slip[ch] = (slip[ch] == DATA_ALIGN_ROLLOVER - 1) ? 0 : slip[ch] + 1;
				end
			end
			align_prev = rx_channel_data_align;
		end
	end

	always @(negedge fast_clock) begin
		logic [BUS_W-1:0] exp_word;
		logic [BUS_W-1:0] file_word;
		logic [NUM_CHANNELS-1:0] care;
		cycle++;
		if (!rst_n) begin
			if (rx_locked === 1'b1 || rx_out_valid === 1'b1) begin
				$display("ERROR at %0t: rx_locked or rx_out_valid high during reset", $time);
				other_count++;
			end
			last_valid_cycle = -1;
			locked_prev = 1'b0;
		end else begin
			if (rx_locked && !locked_prev && en_cycles != LOCK_COUNT + 1) begin
				$display("MISMATCH at %0t: lock rose after %0d enabled cycles, expected %0d",
					$time, en_cycles, LOCK_COUNT + 1);
				mismatch_count++;
			end
			if (!en_at_edge && rx_locked) begin
				$display("MISMATCH at %0t: rx_locked high after pll_enable was low", $time);
				mismatch_count++;
			end
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				if (rx_cda_max[ch] !== (slip[ch] == DATA_ALIGN_ROLLOVER - 1)) begin
					$display("MISMATCH at %0t: channel %0d cda_max %b at slip %0d",
						$time, ch, rx_cda_max[ch], slip[ch]);
					mismatch_count++;
				end
			end
			if (rx_out_valid) begin
				valid_count++;
				if (!rx_locked) begin
					$display("ERROR at %0t: word strobe seen while unlocked", $time);
					other_count++;
				end
				if (last_valid_cycle >= 0 && cycle - last_valid_cycle != DESER_FACTOR) begin
					$display("MISMATCH at %0t: word strobes %0d cycles apart, expected %0d",
						$time, cycle - last_valid_cycle, DESER_FACTOR);
					mismatch_count++;
				end
				last_valid_cycle = cycle;
				if (model_q.size() == 0) begin
					$display("ERROR at %0t: word strobe before a whole word was received", $time);
					other_count++;
				end else begin
					exp_word = model_q.pop_front();
					if (rx_out !== exp_word) begin
						$display("MISMATCH at %0t: rx_out %h, word rule gives %h",
							$time, rx_out, exp_word);
						mismatch_count++;
					end
				end
				if (file_word_q.size() != 0) begin
					file_word = file_word_q.pop_front();
					care = file_care_q.pop_front();
					for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
						if (care[ch] && rx_out[ch*DESER_FACTOR +: DESER_FACTOR] !==
								file_word[ch*DESER_FACTOR +: DESER_FACTOR]) begin
							$display("MISMATCH at %0t: channel %0d got %h, stim file expects %h",
								$time, ch, rx_out[ch*DESER_FACTOR +: DESER_FACTOR],
								file_word[ch*DESER_FACTOR +: DESER_FACTOR]);
							mismatch_count++;
						end
					end
				end
			end
			if (!rx_locked) begin
				last_valid_cycle = -1;
			end
			locked_prev = rx_locked;
		end
	end

endmodule : lvds_rx_monitor

`default_nettype wire

// ==== sim/lvds_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvds_rx_tb
	import lvds_rx_cfg_pkg::*;
();

	localparam int LOCK_COUNT = 16;
	localparam int ROLLOVER = 4;
	localparam int RESET_CYCLES = 10;
	localparam int FILE_FRAMES = 14;
	localparam int RAND_FRAMES = 24;
	localparam int FIELDS = 11;
	localparam int BUS_W = NUM_CHANNELS * DESER_FACTOR;
	localparam int MAX_CYCLES = RESET_CYCLES + LOCK_COUNT
		+ (FILE_FRAMES + RAND_FRAMES + 4) * DESER_FACTOR + 200;

	logic fast_clock;
	logic rst_n;
	logic pll_enable;
	logic [NUM_CHANNELS-1:0] rx_in;
	logic [NUM_CHANNELS-1:0] rx_channel_data_align;
	logic [NUM_CHANNELS-1:0] rx_cda_reset;
	logic [BUS_W-1:0] rx_out;
	logic rx_out_valid;
	logic rx_locked;
	logic [NUM_CHANNELS-1:0] rx_cda_max;

	logic [7:0] stim_mem [FILE_FRAMES*FIELDS];
	logic [31:0] rng;

	lvds_rx_top UUT (
		.fast_clock           (fast_clock),
		.rst_n                (rst_n),
		.rx_in                (rx_in),
		.pll_enable           (pll_enable),
		.rx_channel_data_align(rx_channel_data_align),
		.rx_cda_reset         (rx_cda_reset),
		.rx_out               (rx_out),
		.rx_out_valid         (rx_out_valid),
		.rx_locked            (rx_locked),
		.rx_cda_max           (rx_cda_max)
	);

	lvds_rx_monitor #(
		.LOCK_COUNT         (LOCK_COUNT),
		.DATA_ALIGN_ROLLOVER(ROLLOVER)
	) u_monitor (
		.fast_clock           (fast_clock),
		.rst_n                (rst_n),
		.pll_enable           (pll_enable),
		.rx_in                (rx_in),
		.rx_channel_data_align(rx_channel_data_align),
		.rx_cda_reset         (rx_cda_reset),
		.rx_out               (rx_out),
		.rx_out_valid         (rx_out_valid),
		.rx_locked            (rx_locked),
		.rx_cda_max           (rx_cda_max)
	);

	bind lvds_rx_top lvds_rx_checker #(
		.DATA_ALIGN_ROLLOVER(DATA_ALIGN_ROLLOVER)
	) u_checker (
		.fast_clock  (fast_clock),
		.rst_n       (rst_n),
		.pll_enable  (pll_enable),
		.rx_locked   (rx_locked),
		.rx_out_valid(rx_out_valid),
		.rx_cda_reset(rx_cda_reset),
		.rx_cda_max  (rx_cda_max)
	);

	initial fast_clock = 1'b0;
	always #4 fast_clock = ~fast_clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one word per channel, MSB first, commands only during the first bit
	task automatic send_frame(input logic [BUS_W-1:0] words, input logic [NUM_CHANNELS-1:0] slip,
			input logic [NUM_CHANNELS-1:0] clr);
		for (int b = 0; b < DESER_FACTOR; b++) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				rx_in[ch] = words[ch*DESER_FACTOR + DESER_FACTOR - 1 - b];
			end
			rx_channel_data_align = (b == 0) ? slip : '0;
			rx_cda_reset = (b == 0) ? clr : '0;
			@(negedge fast_clock);
		end
	endtask

	initial begin
		repeat (MAX_CYCLES) @(posedge fast_clock);
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [BUS_W-1:0] words;
		logic [BUS_W-1:0] expect_words;
		logic [NUM_CHANNELS-1:0] slip_mask;
		logic [NUM_CHANNELS-1:0] clr_mask;
		int base;
		rst_n = 1'b0;
		pll_enable = 1'b0;
		rx_in = '0;
		rx_channel_data_align = '0;
		rx_cda_reset = '0;
		rng = 32'd5;
		$readmemh("sim/lvds_rx_stim.txt", stim_mem);
		repeat (RESET_CYCLES) @(negedge fast_clock);
		rst_n = 1'b1;
		@(negedge fast_clock);
		pll_enable = 1'b1;
		do begin
			@(negedge fast_clock);
		end while (!rx_locked);

		// the first bit goes out in the falling edge right after lock
		for (int f = 0; f < FILE_FRAMES; f++) begin
			base = f * FIELDS;
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				words[ch*DESER_FACTOR +: DESER_FACTOR] = stim_mem[base + ch];
				expect_words[ch*DESER_FACTOR +: DESER_FACTOR] = stim_mem[base + 6 + ch];
			end
			u_monitor.add_expect(expect_words, stim_mem[base + 10][NUM_CHANNELS-1:0]);
			send_frame(words, stim_mem[base + 4][NUM_CHANNELS-1:0],
				stim_mem[base + 5][NUM_CHANNELS-1:0]);
		end

		// channel 0 walks up to its max offset and is then cleared from there
		for (int r = 0; r < RAND_FRAMES; r++) begin
			rng = xorshift32(rng);
			slip_mask = (r < ROLLOVER - 1) ? NUM_CHANNELS'(1) : '0;
			clr_mask = (r == ROLLOVER - 1) ? NUM_CHANNELS'(1) : '0;
			u_monitor.add_expect('0, '0);
			send_frame(rng, slip_mask, clr_mask);
		end

		rx_in = '0;
		repeat (2 * DESER_FACTOR) @(negedge fast_clock);
		pll_enable = 1'b0;
		repeat (4) @(negedge fast_clock);
		u_monitor.finish_checks(FILE_FRAMES + RAND_FRAMES);

		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			u_monitor.mismatch_count, u_monitor.other_count, UUT.u_checker.fail_count);
		if (u_monitor.mismatch_count == 0 && u_monitor.other_count == 0
				&& UUT.u_checker.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : lvds_rx_tb

`default_nettype wire

// ==== sim/lvds_rx_stim.txt ====
// tx0 tx1 tx2 tx3 slip_mask reset_mask exp0 exp1 exp2 exp3 care_mask, one frame per line
// channel 1 always sends b4, care bit clear marks a don't-care channel
01 B4 C3 5A 0 0 01 B4 C3 5A F
80 B4 3C A5 0 0 80 B4 3C A5 F
7E B4 FF 00 2 0 7E 00 FF 00 D
55 B4 AA 0F 0 0 55 5A AA 0F F
12 B4 34 56 2 0 12 00 34 56 D
9C B4 E1 2B 0 0 9C 2D E1 2B F
6D B4 47 F0 2 0 6D 00 47 F0 D
3A B4 C5 18 0 0 3A 96 C5 18 F
81 B4 7F 99 2 0 81 00 7F 99 D
E7 B4 24 63 0 0 E7 B4 24 63 F
0C B4 D2 4B 2 0 0C 00 D2 4B D
F1 B4 8E 36 2 0 F1 00 8E 36 D
5B B4 A9 C7 0 2 5B 00 A9 C7 D
2E B4 71 E4 0 0 2E B4 71 E4 F

// ==== all.f ====
rtl/lvds_rx_cfg_pkg.sv
rtl/lvds_rx_types_pkg.sv
rtl/lock_timing_gen.sv
rtl/bitslip_ctrl.sv
rtl/rx_channel.sv
rtl/lvds_rx_top.sv
sim/lvds_rx_checker.sv
sim/lvds_rx_monitor.sv
sim/lvds_rx_tb.sv

// ==== Bender.yml ====
package:
  name: lvds_rx

sources:
  - files:
      - rtl/lvds_rx_cfg_pkg.sv
      - rtl/lvds_rx_types_pkg.sv
      - rtl/lock_timing_gen.sv
      - rtl/bitslip_ctrl.sv
      - rtl/rx_channel.sv
      - rtl/lvds_rx_top.sv
  - target: simulation
    files:
      - sim/lvds_rx_checker.sv
      - sim/lvds_rx_monitor.sv
      - sim/lvds_rx_tb.sv
